// File: build.f
verilog/memPkg.sv
verilog/accessDecoder.sv
verilog/byteLaneRam.sv
verilog/loadAligner.sv
verilog/dataMemory.sv
dv/memChecker.sv
dv/memTb.sv

// File: Makefile
# Verilator flow for the data memory testbench
# Any variable can be overridden, e.g. make sim OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= memTb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/100ps
PASS_TEXT ?= Result: PASSED

SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(OBJ_DIR) -o V$(TOP)

# Output goes to the terminal, the status comes from the search
sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/memTb.sv
// Testbench top for the data memory
// Applies a table of stores and loads and hands expectations to the checker
`timescale 1ns/100ps
`default_nettype none

module memTb;

   localparam int DRAIN_CYCLES = 30;           // Longer than the checker timeout

   // One table row, the name lives in a parallel queue
   typedef struct packed {
      logic                 backToBack;        // No idle cycles before this request
      logic                 write;
      logic                 checkLeds;
      logic [15:0]          addr;
      memPkg::accessSizeT   size;
      logic                 isUnsigned;
      logic [31:0]          wdata;
      logic [31:0]          expData;           // Load data, or LED value for an IO store
   } stepT;

   logic                          clk = 1'b0;
   logic                          mem_rstrb;
   memPkg::memReqT                req;
   memPkg::memRespT               resp;
   logic [memPkg::LED_WIDTH-1:0]  leds;
   stepT                          steps[$];
   string                         stepNames[$];
   int                            seed;
   logic                          drained;

   always #50 clk = ~clk;                      // 100 ns period

   dataMemory DUT (
      .clk       (clk),
      .mem_rstrb (mem_rstrb),
      .req       (req),
      .resp      (resp),
      .leds      (leds)
   );

   memChecker respChecker (
      .clk       (clk),
      .mem_rstrb (mem_rstrb),
      .resp      (resp),
      .leds      (leds)
   );

   task automatic addStep(input bit b2b, input bit write, input bit checkLeds,
                          input logic [15:0] addr, input memPkg::accessSizeT size,
                          input bit isUnsigned, input logic [31:0] wdata,
                          input logic [31:0] expData, input string name);
      stepT step;
      step = '{b2b, write, checkLeds, addr, size, isUnsigned, wdata, expData};
      steps.push_back(step);
      stepNames.push_back(name);
   endtask

   task automatic addStore(input bit b2b, input logic [15:0] addr,
                           input memPkg::accessSizeT size, input logic [31:0] wdata);
      addStep(b2b, 1'b1, 1'b0, addr, size, 1'b0, wdata, 32'h0, "store");
   endtask

   task automatic addLoad(input bit b2b, input logic [15:0] addr,
                          input memPkg::accessSizeT size, input bit isUnsigned,
                          input logic [31:0] expData, input string name);
      addStep(b2b, 1'b0, 1'b0, addr, size, isUnsigned, 32'h0, expData, name);
   endtask

   task automatic buildTable();
      // Word store then load of the same word on the next cycle
      addStore(1'b0, 16'h0010, memPkg::SIZE_WORD, 32'hDEAD_BEEF);
      addLoad (1'b1, 16'h0010, memPkg::SIZE_WORD, 1'b0, 32'hDEAD_BEEF, "word store/load");
      // Byte merge, upper bits of wdata must not leak into other lanes
      addStore(1'b0, 16'h0020, memPkg::SIZE_BYTE, 32'hAAAA_AA11);
      addStore(1'b1, 16'h0021, memPkg::SIZE_BYTE, 32'hBBBB_BB22);
      addStore(1'b0, 16'h0022, memPkg::SIZE_BYTE, 32'hCCCC_CC33);
      addStore(1'b1, 16'h0023, memPkg::SIZE_BYTE, 32'hDDDD_DD44);
      addLoad (1'b1, 16'h0020, memPkg::SIZE_WORD, 1'b0, 32'h4433_2211, "byte merge");
      addStore(1'b0, 16'h0022, memPkg::SIZE_HALF, 32'h1234_BEEF);
      addLoad (1'b1, 16'h0020, memPkg::SIZE_WORD, 1'b0, 32'hBEEF_2211, "half store offset 2");
      // Every field of this word has its top bit set
      addStore(1'b0, 16'h0030, memPkg::SIZE_WORD, 32'h90F4_8B85);
      addLoad (1'b0, 16'h0030, memPkg::SIZE_BYTE, 1'b0, 32'hFFFF_FF85, "lb offset 0");
      addLoad (1'b1, 16'h0030, memPkg::SIZE_BYTE, 1'b1, 32'h0000_0085, "lbu offset 0");
      addLoad (1'b1, 16'h0031, memPkg::SIZE_BYTE, 1'b0, 32'hFFFF_FF8B, "lb offset 1");
      addLoad (1'b1, 16'h0031, memPkg::SIZE_BYTE, 1'b1, 32'h0000_008B, "lbu offset 1");
      addLoad (1'b1, 16'h0032, memPkg::SIZE_BYTE, 1'b0, 32'hFFFF_FFF4, "lb offset 2");
      addLoad (1'b1, 16'h0032, memPkg::SIZE_BYTE, 1'b1, 32'h0000_00F4, "lbu offset 2");
      addLoad (1'b1, 16'h0033, memPkg::SIZE_BYTE, 1'b0, 32'hFFFF_FF90, "lb offset 3");
      addLoad (1'b1, 16'h0033, memPkg::SIZE_BYTE, 1'b1, 32'h0000_0090, "lbu offset 3");
      addLoad (1'b0, 16'h0030, memPkg::SIZE_HALF, 1'b0, 32'hFFFF_8B85, "lh offset 0");
      addLoad (1'b1, 16'h0030, memPkg::SIZE_HALF, 1'b1, 32'h0000_8B85, "lhu offset 0");
      addLoad (1'b1, 16'h0032, memPkg::SIZE_HALF, 1'b0, 32'hFFFF_90F4, "lh offset 2");
      addLoad (1'b1, 16'h0032, memPkg::SIZE_HALF, 1'b1, 32'h0000_90F4, "lhu offset 2");
      addLoad (1'b0, 16'h0020, memPkg::SIZE_BYTE, 1'b0, 32'h0000_0011, "lb positive byte");
      // LED word in the IO page, RAM below it keeps its word
      addStore(1'b0, 16'h0004, memPkg::SIZE_WORD, 32'h1234_5678);
      addStep (1'b0, 1'b1, 1'b1, 16'h4004, memPkg::SIZE_WORD, 1'b0, 32'hFFFF_FFF6,
               32'h0000_0016, "led store");
      addLoad (1'b1, 16'h4004, memPkg::SIZE_WORD, 1'b0, 32'h0000_0016, "led load");
      addLoad (1'b0, 16'h0004, memPkg::SIZE_WORD, 1'b0, 32'h1234_5678, "ram under led word");
      // Pipelined loads, answers in request order
      addLoad (1'b0, 16'h0010, memPkg::SIZE_WORD, 1'b0, 32'hDEAD_BEEF, "burst load 0");
      addLoad (1'b1, 16'h0020, memPkg::SIZE_WORD, 1'b0, 32'hBEEF_2211, "burst load 1");
      addLoad (1'b1, 16'h0004, memPkg::SIZE_WORD, 1'b0, 32'h1234_5678, "burst load 2");
      addLoad (1'b1, 16'h0030, memPkg::SIZE_WORD, 1'b0, 32'h90F4_8B85, "burst load 3");
   endtask

   // Drive each row 1 ns after a rising edge
   task automatic runTable();
      stepT step;
      int   idle;
      for (int i = 0; i < steps.size(); i++) begin
         step = steps[i];
         if (!step.backToBack) begin
            idle = 1 + ($unsigned($random(seed)) % 4);
            repeat (idle) begin
               @(posedge clk);
               #1 req = '0;
            end
         end
         @(posedge clk);
         #1;
         req.valid      = 1'b1;
         req.write      = step.write;
         req.addr       = step.addr;
         req.size       = step.size;
         req.isUnsigned = step.isUnsigned;
         req.wdata      = step.wdata;
         if (!step.write) begin
            respChecker.expectLoad(step.expData, stepNames[i]);
         end else if (step.checkLeds) begin
            respChecker.expectLeds(step.expData[memPkg::LED_WIDTH-1:0], stepNames[i]);
         end
      end
      @(posedge clk);
      #1 req = '0;                             // Last strobe lasts one cycle
   endtask

   initial begin
      seed      = 32'h2351_3c97;
      mem_rstrb = 1'b1;
      req       = '0;
      drained   = 1'b0;
      buildTable();
      repeat (3) @(posedge clk);
      #1 mem_rstrb = 1'b0;
      respChecker.checkIdle("after reset");
      runTable();
      for (int waitCount = 0; waitCount < DRAIN_CYCLES; waitCount++) begin
         @(posedge clk);
         if (respChecker.allSettled()) begin
            drained = 1'b1;
            break;
         end
      end
      if (!drained) begin
         $display("Checks still outstanding after %0d idle cycles", DRAIN_CYCLES);
      end
      $display("Tests: %0d passed, %0d failed", respChecker.passCount, respChecker.failCount);
      if (drained && respChecker.failCount == 0 && respChecker.passCount > 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: dv/memChecker.sv
// Response checker for the data memory testbench
// Compares load data and the LED port against queued expectations
`timescale 1ns/100ps
`default_nettype none

module memChecker (
   input wire                              clk,
   input wire                              mem_rstrb,
   input wire memPkg::memRespT             resp,
   input wire [memPkg::LED_WIDTH-1:0]      leds
);

   localparam int RESP_TIMEOUT = 20;           // Cycles a load may wait for its answer

   logic [memPkg::WORD_WIDTH-1:0] expData[$];  // Oldest load first
   string                         expName[$];
   int                            expDue[$];   // Falling edge that must carry the answer
   int                            cycleCount = 0;
   int                            waitCycles = 0;
   logic                          ledArmed = 1'b0;
   int                            ledDelay = 0;
   logic [memPkg::LED_WIDTH-1:0]  ledExpected;
   string                         ledName;
   int                            passCount = 0;
   int                            failCount = 0;

   // Called in the request cycle, the answer shows at the second falling edge
   task automatic expectLoad(input logic [31:0] data, input string name);
      expData.push_back(data);
      expName.push_back(name);
      expDue.push_back(cycleCount + 2);
   endtask

   // Store strobe is still in flight so the compare waits one more falling edge
   task automatic expectLeds(input logic [memPkg::LED_WIDTH-1:0] value, input string name);
      ledExpected = value;
      ledName     = name;
      ledDelay    = 1;
      ledArmed    = 1'b1;
   endtask

   function automatic bit allSettled();
      return (expData.size() == 0) && !ledArmed;
   endfunction

   task automatic reportCheck(input logic [31:0] expected, input logic [31:0] actual,
                              input string name);
      if (actual === expected) begin
         passCount++;
         $display("ok      %s (%h)", name, actual);
      end else begin
         failCount++;
         $display("FAILED at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
      end
   endtask

   // Idle outputs straight after reset
   task automatic checkIdle(input string name);
      reportCheck(32'h0, {31'h0, resp.valid}, {name, " resp.valid"});
      reportCheck(32'h0, {27'h0, leds}, {name, " leds"});
   endtask

   // Outputs settle well before the falling edge
   always @(negedge clk) begin
      cycleCount++;
      if (!mem_rstrb) begin
         if (resp.valid === 1'b1) begin
            if (expData.size() == 0) begin
               failCount++;
               $display("Response %h arrived at %0d ns with no load outstanding",
                        resp.data, $time);
            end else if (expDue[0] != cycleCount) begin
               failCount++;
               $display("Load %s was answered at %0d ns and not in the cycle after its request",
                        expName[0], $time);
               expData.delete(0);
               expName.delete(0);
               expDue.delete(0);
            end else begin
               expDue.delete(0);
               reportCheck(expData.pop_front(), resp.data, expName.pop_front());
            end
            waitCycles = 0;
         end else if (expData.size() != 0) begin
            waitCycles++;
            if (waitCycles >= RESP_TIMEOUT) begin
               failCount++;
               $display("Load %s got no response within %0d cycles", expName[0], RESP_TIMEOUT);
               expData.delete(0);
               expName.delete(0);
               expDue.delete(0);
               waitCycles = 0;
            end
         end else begin
            waitCycles = 0;                     // Nothing pending
         end
         if (ledArmed) begin
            if (ledDelay > 0) begin
               ledDelay--;
            end else begin
               reportCheck({27'h0, ledExpected}, {27'h0, leds}, ledName);
               ledArmed = 1'b0;
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: verilog/dataMemory.sv
// Data memory top: request decoder, four byte-lane RAMs and the load aligner
// A load answers one cycle after its strobe, stores give no response
`timescale 1ns/100ps
`default_nettype none

module dataMemory (
   input  wire                              clk,
   input  wire                              mem_rstrb,
   input  wire memPkg::memReqT              req,
   output memPkg::memRespT                  resp,
   output wire [memPkg::LED_WIDTH-1:0]      leds
);

   wire memPkg::laneWriteT                                   laneCmd;
   wire memPkg::loadTagT                                     loadTag;
   wire [memPkg::NUM_LANES-1:0][memPkg::LANE_WIDTH-1:0]      laneData;   // Registered lane bytes
   wire [memPkg::LED_WIDTH-1:0]                              ledValue;

   // Request decode, LED register, load tag
   accessDecoder decoder (
      .clk       (clk),
      .mem_rstrb (mem_rstrb),
      .req       (req),
      .laneCmd   (laneCmd),
      .loadTag   (loadTag),
      .leds      (ledValue)
   );

   assign leds = ledValue;

   // One RAM per byte lane, each takes its own enable and data byte
   generate
      for (genvar lane = 0; lane < memPkg::NUM_LANES; lane++) begin : gLane
         byteLaneRam ram (
            .clk         (clk),
            .wordIndex   (laneCmd.wordIndex),
            .writeEnable (laneCmd.enable[lane]),
            .readEnable  (laneCmd.readEnable),
            .writeData   (laneCmd.data[lane]),
            .readData    (laneData[lane])
         );
      end
   endgenerate

   // Field select and extension, combinational
   loadAligner aligner (
      .clk       (clk),
      .mem_rstrb (mem_rstrb),
      .loadTag   (loadTag),
      .laneData  (laneData),
      .ledValue  (ledValue),
      .resp      (resp)
   );

endmodule

`default_nettype wire

// File: verilog/loadAligner.sv
// Load result path with field select and sign or zero extension
// IO loads return the LED register
`timescale 1ns/100ps
`default_nettype none

module loadAligner (
   input  wire                                                    clk,
   input  wire                                                    mem_rstrb,
   input  wire memPkg::loadTagT                                   loadTag,
   input  wire [memPkg::NUM_LANES-1:0][memPkg::LANE_WIDTH-1:0]    laneData,
   input  wire [memPkg::LED_WIDTH-1:0]                            ledValue,
   output memPkg::memRespT                                        resp
);

   logic [memPkg::WORD_WIDTH-1:0]   fullWord;
   logic [15:0]                     halfword;
   logic [memPkg::LANE_WIDTH-1:0]   loadByte;
   logic                            loadSign;
   logic [memPkg::WORD_WIDTH-1:0]   ramData;

   assign fullWord = laneData;                              // Lane 3 lands in the top byte

   // Offset bit 1 picks the halfword, bit 0 the byte inside it
   assign halfword = loadTag.offset[1] ? fullWord[31:16] : fullWord[15:0];
   assign loadByte = loadTag.offset[0] ? halfword[15:8] : halfword[7:0];

   // Sign bit of the selected field is forced low for unsigned loads
   assign loadSign = ~loadTag.isUnsigned &
                     ((loadTag.size == memPkg::SIZE_BYTE) ? loadByte[7] : halfword[15]);

   always_comb begin
      case (loadTag.size)
         memPkg::SIZE_BYTE: ramData = {{24{loadSign}}, loadByte};
         memPkg::SIZE_HALF: ramData = {{16{loadSign}}, halfword};
         default:           ramData = fullWord;
      endcase
   end

   always_comb begin
      resp.valid = loadTag.valid;
      if (loadTag.isIo) begin
         // LED word answers anywhere in the IO page
         resp.data = {{(memPkg::WORD_WIDTH - memPkg::LED_WIDTH){1'b0}}, ledValue};
      end else begin
         resp.data = ramData;
      end
   end

   // Lane bytes only move on the edge that takes a RAM load
   assert property (@(posedge clk) disable iff (mem_rstrb)
      !(loadTag.valid && !loadTag.isIo) |-> (laneData === $past(laneData)))
      else $error("lane data changed without a RAM load behind it");

endmodule

`default_nettype wire

// File: verilog/byteLaneRam.sv
// One byte lane of the data memory
// Synchronous write, registered read that holds between reads
`timescale 1ns/100ps
`default_nettype none

module byteLaneRam (
   input  wire                                    clk,
   input  wire [memPkg::WORD_INDEX_WIDTH-1:0]     wordIndex,
   input  wire                                    writeEnable,
   input  wire                                    readEnable,
   input  wire [memPkg::LANE_WIDTH-1:0]           writeData,
   output logic [memPkg::LANE_WIDTH-1:0]          readData
);

   // Lane storage, contents undefined after reset
   logic [memPkg::LANE_WIDTH-1:0] mem [memPkg::RAM_WORDS];

   always_ff @(posedge clk) begin
      if (writeEnable) begin
         mem[wordIndex] <= writeData;
      end
   end

   // Read port, output register keeps the last byte
   always_ff @(posedge clk) begin
      if (readEnable) begin
         readData <= mem[wordIndex];   // Sees a write from the previous edge
      end
   end

endmodule

`default_nettype wire

// File: verilog/accessDecoder.sv
// Request decoder for page select, store mask, lane data and the LED register
// Also registers the tag of each load for the aligner
`timescale 1ns/100ps
`default_nettype none

module accessDecoder (
   input  wire                                clk,
   input  wire                                mem_rstrb,
   input  wire memPkg::memReqT                req,
   output memPkg::laneWriteT                  laneCmd,
   output memPkg::loadTagT                    loadTag,
   output logic [memPkg::LED_WIDTH-1:0]       leds
);

   logic                                isIo;
   logic                                isLoad;
   logic                                ramStore;
   logic                                ledStore;
   logic [memPkg::OFFSET_WIDTH-1:0]     offset;
   logic [memPkg::NUM_LANES-1:0]        writeMask;
   logic [memPkg::LANE_WIDTH-1:0]       lowByte;
   logic [memPkg::LANE_WIDTH-1:0]       secondByte;

   assign isIo     = req.addr[memPkg::IO_SELECT_BIT];
   assign isLoad   = req.valid & ~req.write;
   assign ramStore = req.valid & req.write & ~isIo;
   // Only the LED word is writable in the IO page
   assign ledStore = req.valid & req.write & isIo & req.addr[memPkg::LED_WORD_BIT];

   assign lowByte    = req.wdata[7:0];
   assign secondByte = req.wdata[15:8];

   // Misaligned offset bits are dropped without a trap
   always_comb begin
      case (req.size)
         memPkg::SIZE_BYTE: offset = req.addr[memPkg::OFFSET_WIDTH-1:0];
         memPkg::SIZE_HALF: offset = {req.addr[1], 1'b0};    // Bit 0 ignored
         default:           offset = '0;                     // Words are always aligned
      endcase
   end

   // Store mask with one bit per byte lane
   always_comb begin
      case (req.size)
         memPkg::SIZE_BYTE: writeMask = memPkg::NUM_LANES'(1) << offset;  // One-hot
         memPkg::SIZE_HALF: writeMask = offset[1] ? 4'b1100 : 4'b0011;
         default:           writeMask = 4'b1111;
      endcase
   end

   always_comb begin
      laneCmd.wordIndex  = req.addr[memPkg::OFFSET_WIDTH +: memPkg::WORD_INDEX_WIDTH];
      laneCmd.enable     = ramStore ? writeMask : '0;    // IO accesses never touch RAM
      laneCmd.readEnable = isLoad & ~isIo;
      // Low byte or low halfword replicated into the addressed lanes
      laneCmd.data[0] = lowByte;
      laneCmd.data[1] = offset[0] ? lowByte : secondByte;
      laneCmd.data[2] = offset[1] ? lowByte : req.wdata[23:16];
      if (offset[0]) begin
         laneCmd.data[3] = lowByte;                      // Byte at offset 1 or 3
      end else if (offset[1]) begin
         laneCmd.data[3] = secondByte;                   // Upper halfword
      end else begin
         laneCmd.data[3] = req.wdata[31:24];
      end
   end

   // Load tag and LED register, both taken on the request edge
   always_ff @(posedge clk) begin
      loadTag.offset     <= offset;
      loadTag.size       <= req.size;
      loadTag.isUnsigned <= req.isUnsigned;
      loadTag.isIo       <= isIo;
      if (mem_rstrb) begin
         loadTag.valid <= 1'b0;
         leds          <= '0;
      end else begin
         loadTag.valid <= isLoad;                        // Answered on the next cycle
         if (ledStore) begin
            leds <= req.wdata[memPkg::LED_WIDTH-1:0];
         end
      end
   end

   // A byte store hits exactly one lane and that lane carries the low byte
   assert property (@(posedge clk) disable iff (mem_rstrb)
      (ramStore && req.size == memPkg::SIZE_BYTE) |->
         ($onehot(laneCmd.enable) &&
          laneCmd.data[req.addr[memPkg::OFFSET_WIDTH-1:0]] ==
             req.wdata[memPkg::LANE_WIDTH-1:0]))
      else $error("byte store enables %b lanes or misplaces its byte", laneCmd.enable);

endmodule

`default_nettype wire

// File: verilog/memPkg.sv
// Shared widths, address map and struct types for the word-organized data memory
// Sizes follow the load/store funct3 coding
`default_nettype none

package memPkg;

   // Bus and array geometry
   localparam int ADDR_WIDTH       = 16;     // Byte address
   localparam int WORD_WIDTH       = 32;     // Data bus
   localparam int NUM_LANES        = 4;      // Bytes per word
   localparam int LANE_WIDTH       = 8;
   localparam int OFFSET_WIDTH     = 2;      // Byte offset inside a word
   localparam int RAM_WORDS        = 2048;   // Depth of every lane
   localparam int WORD_INDEX_WIDTH = 11;

   // Address map
   localparam int IO_SELECT_BIT    = 14;     // Set means IO page
   localparam int LED_WORD_BIT     = 2;      // One-hot word select in the IO page
   localparam int LED_WIDTH        = 5;

   // Same coding as funct3[1:0] of loads and stores
   typedef enum logic [1:0] {
      SIZE_BYTE = 2'b00,
      SIZE_HALF = 2'b01,
      SIZE_WORD = 2'b10
   } accessSizeT;

   // One load/store request, valid for a single cycle
   typedef struct packed {
      logic                  valid;
      logic                  write;        // 0 means load
      logic [ADDR_WIDTH-1:0] addr;
      accessSizeT            size;
      logic                  isUnsigned;   // funct3[2] of a load
      logic [WORD_WIDTH-1:0] wdata;
   } memReqT;

   // Command fanned out to the byte lanes in the request cycle
   typedef struct packed {
      logic [WORD_INDEX_WIDTH-1:0]             wordIndex;
      logic [NUM_LANES-1:0]                    enable;      // Write mask
      logic                                    readEnable;
      logic [NUM_LANES-1:0][LANE_WIDTH-1:0]    data;        // Lane 0 is the low byte
   } laneWriteT;

   // What the aligner needs to know about the load in flight
   typedef struct packed {
      logic                    valid;
      logic [OFFSET_WIDTH-1:0] offset;
      accessSizeT              size;
      logic                    isUnsigned;
      logic                    isIo;
   } loadTagT;

   // Load result, one cycle after the request
   typedef struct packed {
      logic                  valid;
      logic [WORD_WIDTH-1:0] data;
   } memRespT;

endpackage

`default_nettype wire
